// File: Bender.yml
package:
  name: icache_xbar

sources:
  # Crossbar RTL, package first
  - source/icache_xbar_pkg.sv
  - source/bank_arbiter.sv
  - source/request_mux.sv
  - source/response_router.sv
  - source/icache_xbar_top.sv

  # Testbench
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_checker.sv
      - tests/tb_icache_xbar.sv

// File: source/bank_arbiter.sv
// Per bank round-robin arbitration
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter
(
        input  logic                                                clk,
        input  logic                                                arst_n_i,

        // Request matrix, one master vector per bank
        input  logic [icache_xbar_pkg::N_BANK-1:0][icache_xbar_pkg::N_MASTER-1:0] bank_req_i,
        input  logic [icache_xbar_pkg::N_BANK-1:0]                  data_gnt_i,    // Bank ready

        output logic [icache_xbar_pkg::N_BANK-1:0]                  win_valid_o,   // Bank has a winner
        output icache_xbar_pkg::master_idx_t [icache_xbar_pkg::N_BANK-1:0] win_idx_o,
        output logic [icache_xbar_pkg::N_BANK-1:0]                  data_req_o,    // To the banks
        output logic [icache_xbar_pkg::N_MASTER-1:0]                data_gnt_o     // To the masters
);

        // Round-robin pointers, one per bank
        icache_xbar_pkg::master_idx_t [icache_xbar_pkg::N_BANK-1:0] rr_ptr_q;
        icache_xbar_pkg::master_idx_t [icache_xbar_pkg::N_BANK-1:0] rr_ptr_next;

        logic [icache_xbar_pkg::N_BANK-1:0]                         win_valid;
        icache_xbar_pkg::master_idx_t [icache_xbar_pkg::N_BANK-1:0] win_idx;
        logic [icache_xbar_pkg::N_BANK-1:0]                         bank_accept;  // req and gnt

        //////////////////////////////////////////////////
        // Winner selection
        //////////////////////////////////////////////////

        // First requester at or after the pointer, wrapping around
        always_comb
        begin
                icache_xbar_pkg::master_idx_t cand;

                cand = '0;
                for (int unsigned b = 0; b < icache_xbar_pkg::N_BANK; b++)
                begin
                        win_valid[b] = 1'b0;
                        win_idx[b]   = rr_ptr_q[b];    // Idle bank shows the pointer
                        for (int unsigned off = 0; off < icache_xbar_pkg::N_MASTER; off++)
                        begin
                                cand = icache_xbar_pkg::master_idx_t'(
                                        (rr_ptr_q[b] + off) % icache_xbar_pkg::N_MASTER);
                                if (!win_valid[b] && bank_req_i[b][cand])
                                begin
                                        win_valid[b] = 1'b1;
                                        win_idx[b]   = cand;    // Closest to the pointer wins
                                end
                        end
                end
        end

        assign win_valid_o = win_valid;
        assign win_idx_o   = win_idx;
        assign data_req_o  = win_valid;               // Winner is shown even without gnt
        assign bank_accept = win_valid & data_gnt_i;  // Transfer happens this cycle

        //////////////////////////////////////////////////
        // Master grants and pointer update
        //////////////////////////////////////////////////

        // A master targets one bank, so at most one bank grants it
        always_comb
        begin
                data_gnt_o = '0;
                for (int unsigned b = 0; b < icache_xbar_pkg::N_BANK; b++)
                begin
                        if (bank_accept[b])
                                data_gnt_o[win_idx[b]] = 1'b1;
                end
        end

        // Next pointer lands on the master after the winner
        always_comb
        begin
                for (int unsigned b = 0; b < icache_xbar_pkg::N_BANK; b++)
                begin
                        rr_ptr_next[b] = icache_xbar_pkg::master_idx_t'(
                                (win_idx[b] + 1) % icache_xbar_pkg::N_MASTER);
                end
        end

        always_ff @(posedge clk or negedge arst_n_i)
        begin
                if (!arst_n_i)
                begin
                        rr_ptr_q <= '0;     // Every bank starts at master 0
                end
                else
                begin
                        for (int unsigned b = 0; b < icache_xbar_pkg::N_BANK; b++)
                        begin
                                if (bank_accept[b])
                                        rr_ptr_q[b] <= rr_ptr_next[b];
                                // Pointer holds while the bank stalls
                        end
                end
        end

endmodule

`default_nettype wire

// File: source/icache_xbar_pkg.sv
// Instruction cache crossbar definitions
`default_nettype none

package icache_xbar_pkg;

        //////////////////////////////////////////////////
        // Crossbar sizes
        //////////////////////////////////////////////////

        localparam int unsigned N_MASTER   = 4;      // Fetch ports
        localparam int unsigned N_BANK     = 4;      // Interleaved cache banks, power of two
        localparam int unsigned ADDR_WIDTH = 32;     // Fetch address
        localparam int unsigned DATA_WIDTH = 32;     // One instruction word

        // Bank index sits right above the 32 byte line offset
        localparam int unsigned BLI_LSB          = 5;
        localparam int unsigned BANK_SEL_WIDTH   = $clog2(N_BANK);   // 2 for four banks
        localparam int unsigned MASTER_IDX_WIDTH = $clog2(N_MASTER); // Binary master number

        //////////////////////////////////////////////////
        // Types
        //////////////////////////////////////////////////

        typedef logic [ADDR_WIDTH-1:0]       addr_t;       // Fetch address
        typedef logic [DATA_WIDTH-1:0]       data_t;       // Instruction word
        typedef logic [BANK_SEL_WIDTH-1:0]   bank_sel_t;   // Target bank
        typedef logic [MASTER_IDX_WIDTH-1:0] master_idx_t; // Master number
        typedef logic [N_MASTER-1:0]         master_id_t;  // One-hot tag carried by the bank

endpackage

`default_nettype wire

// File: source/icache_xbar_top.sv
// Instruction cache crossbar top
`timescale 1ns/1ps
`default_nettype none

module icache_xbar_top
(
        input  logic                                                       clk,
        input  logic                                                       arst_n_i,

        //////////////////////////////////////////////////
        // Fetch ports
        input  logic [icache_xbar_pkg::N_MASTER-1:0]                       data_req_i,
        input  icache_xbar_pkg::addr_t [icache_xbar_pkg::N_MASTER-1:0]     data_add_i,
        output logic [icache_xbar_pkg::N_MASTER-1:0]                       data_gnt_o,
        output logic [icache_xbar_pkg::N_MASTER-1:0]                       data_r_valid_o,
        output icache_xbar_pkg::data_t [icache_xbar_pkg::N_MASTER-1:0]     data_r_rdata_o,

        //////////////////////////////////////////////////
        // Cache banks
        output logic [icache_xbar_pkg::N_BANK-1:0]                         data_req_o,
        output icache_xbar_pkg::addr_t [icache_xbar_pkg::N_BANK-1:0]       data_add_o,
        output icache_xbar_pkg::master_id_t [icache_xbar_pkg::N_BANK-1:0]  data_id_o,
        input  logic [icache_xbar_pkg::N_BANK-1:0]                         data_gnt_i,
        input  logic [icache_xbar_pkg::N_BANK-1:0]                         data_r_valid_i, // Always taken
        input  icache_xbar_pkg::master_id_t [icache_xbar_pkg::N_BANK-1:0]  data_r_id_i,
        input  icache_xbar_pkg::data_t [icache_xbar_pkg::N_BANK-1:0]       data_r_rdata_i
);

        // Request matrix from the decoders
        logic [icache_xbar_pkg::N_BANK-1:0][icache_xbar_pkg::N_MASTER-1:0] bank_req;

        // Arbitration result per bank
        logic [icache_xbar_pkg::N_BANK-1:0]                                win_valid;
        icache_xbar_pkg::master_idx_t [icache_xbar_pkg::N_BANK-1:0]        win_idx;

        // Round-robin control, also drives the req/gnt handshakes
        bank_arbiter i_bank_arbiter
        (
                .clk            ( clk            ),
                .arst_n_i       ( arst_n_i       ),
                .bank_req_i     ( bank_req       ),
                .data_gnt_i     ( data_gnt_i     ),
                .win_valid_o    ( win_valid      ),
                .win_idx_o      ( win_idx        ),
                .data_req_o     ( data_req_o     ),
                .data_gnt_o     ( data_gnt_o     )
        );

        // Bank decode and winner payload
        request_mux i_request_mux
        (
                .data_req_i     ( data_req_i     ),
                .data_add_i     ( data_add_i     ),
                .win_valid_i    ( win_valid      ),
                .win_idx_i      ( win_idx        ),
                .bank_req_o     ( bank_req       ),
                .data_add_o     ( data_add_o     ),
                .data_id_o      ( data_id_o      )
        );

        // Return path by one-hot tag
        response_router i_response_router
        (
                .data_r_valid_i ( data_r_valid_i ),
                .data_r_id_i    ( data_r_id_i    ),
                .data_r_rdata_i ( data_r_rdata_i ),
                .data_r_valid_o ( data_r_valid_o ),
                .data_r_rdata_o ( data_r_rdata_o )
        );

endmodule

`default_nettype wire

// File: source/request_mux.sv
// Crossbar request routing
`timescale 1ns/1ps
`default_nettype none

module request_mux
(
        // Master side
        input  logic [icache_xbar_pkg::N_MASTER-1:0]                 data_req_i,
        input  icache_xbar_pkg::addr_t [icache_xbar_pkg::N_MASTER-1:0] data_add_i,

        // From the arbiters
        input  logic [icache_xbar_pkg::N_BANK-1:0]                   win_valid_i,
        input  icache_xbar_pkg::master_idx_t [icache_xbar_pkg::N_BANK-1:0] win_idx_i,

        // Request matrix to the arbiters
        output logic [icache_xbar_pkg::N_BANK-1:0][icache_xbar_pkg::N_MASTER-1:0] bank_req_o,

        // Bank side payload
        output icache_xbar_pkg::addr_t [icache_xbar_pkg::N_BANK-1:0]     data_add_o,
        output icache_xbar_pkg::master_id_t [icache_xbar_pkg::N_BANK-1:0] data_id_o
);

        // Decoded target bank of every master
        icache_xbar_pkg::bank_sel_t [icache_xbar_pkg::N_MASTER-1:0] bank_sel;

        //////////////////////////////////////////////////
        // Bank decode
        //////////////////////////////////////////////////

        genvar m, b;

        generate
                for (m = 0; m < icache_xbar_pkg::N_MASTER; m++)
                begin : g_decode
                        // Line interleaving, bits above the line offset
                        assign bank_sel[m] = data_add_i[m][icache_xbar_pkg::BLI_LSB +:
                                                           icache_xbar_pkg::BANK_SEL_WIDTH];
                end

                // Transpose into one master vector per bank
                for (b = 0; b < icache_xbar_pkg::N_BANK; b++)
                begin : g_bank_req
                        for (m = 0; m < icache_xbar_pkg::N_MASTER; m++)
                        begin : g_master
                                assign bank_req_o[b][m] = data_req_i[m] &&
                                        (bank_sel[m] == icache_xbar_pkg::bank_sel_t'(b));
                        end
                end
        endgenerate

        //////////////////////////////////////////////////
        // Winner payload
        //////////////////////////////////////////////////

        // Address of the winning master on each bank
        always_comb
        begin
                for (int unsigned i = 0; i < icache_xbar_pkg::N_BANK; i++)
                begin
                        data_add_o[i] = data_add_i[win_idx_i[i]];
                end
        end

        // One-hot tag of the winner, zero on an idle bank
        always_comb
        begin
                for (int unsigned i = 0; i < icache_xbar_pkg::N_BANK; i++)
                begin
                        if (win_valid_i[i])
                        begin
                                data_id_o[i] = icache_xbar_pkg::master_id_t'(1) << win_idx_i[i];
                        end
                        else
                        begin
                                data_id_o[i] = '0;     // Nobody tagged
                        end
                end
        end

endmodule

`default_nettype wire

// File: source/response_router.sv
// Crossbar response steering
`timescale 1ns/1ps
`default_nettype none

module response_router
(
        // Bank responses, never back-pressured
        input  logic [icache_xbar_pkg::N_BANK-1:0]                        data_r_valid_i,
        input  icache_xbar_pkg::master_id_t [icache_xbar_pkg::N_BANK-1:0] data_r_id_i,
        input  icache_xbar_pkg::data_t [icache_xbar_pkg::N_BANK-1:0]      data_r_rdata_i,

        // Per master response
        output logic [icache_xbar_pkg::N_MASTER-1:0]                      data_r_valid_o,
        output icache_xbar_pkg::data_t [icache_xbar_pkg::N_MASTER-1:0]    data_r_rdata_o
);

        // Hit matrix, bank b carries a response for master m
        logic [icache_xbar_pkg::N_MASTER-1:0][icache_xbar_pkg::N_BANK-1:0] resp_hit;

        //////////////////////////////////////////////////
        // ID match
        //////////////////////////////////////////////////

        genvar m, b;

        generate
                for (m = 0; m < icache_xbar_pkg::N_MASTER; m++)
                begin : g_hit
                        for (b = 0; b < icache_xbar_pkg::N_BANK; b++)
                        begin : g_bank
                                // Master bit set in the returned one-hot tag
                                assign resp_hit[m][b] = data_r_valid_i[b] & data_r_id_i[b][m];
                        end

                        assign data_r_valid_o[m] = |resp_hit[m];
                end
        endgenerate

        //////////////////////////////////////////////////
        // Data steering
        //////////////////////////////////////////////////

        // AND-OR mux, one outstanding fetch per master keeps hits one-hot
        always_comb
        begin
                for (int unsigned i = 0; i < icache_xbar_pkg::N_MASTER; i++)
                begin
                        data_r_rdata_o[i] = '0;
                        for (int unsigned j = 0; j < icache_xbar_pkg::N_BANK; j++)
                        begin
                                data_r_rdata_o[i] = data_r_rdata_o[i] |
                                        ({icache_xbar_pkg::DATA_WIDTH{resp_hit[i][j]}}
                                         & data_r_rdata_i[j]);
                        end
                end
        end

endmodule

`default_nettype wire

// File: sources.f
source/icache_xbar_pkg.sv
source/bank_arbiter.sv
source/request_mux.sv
source/response_router.sv
source/icache_xbar_top.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_icache_xbar.sv

// File: tests/tb_checker.sv
// Crossbar port checker
`timescale 1ns/1ps
`default_nettype none

module tb_checker
(
        input  logic                                                      clk,
        input  logic                                                      arst_n_i,

        // Watched DUT ports
        input  logic [icache_xbar_pkg::N_MASTER-1:0]                      req_i,
        input  icache_xbar_pkg::addr_t [icache_xbar_pkg::N_MASTER-1:0]    add_i,
        input  logic [icache_xbar_pkg::N_MASTER-1:0]                      gnt_i,
        input  logic [icache_xbar_pkg::N_MASTER-1:0]                      r_valid_i,
        input  icache_xbar_pkg::data_t [icache_xbar_pkg::N_MASTER-1:0]    r_rdata_i,
        input  logic [icache_xbar_pkg::N_BANK-1:0]                        bank_req_i,
        input  icache_xbar_pkg::addr_t [icache_xbar_pkg::N_BANK-1:0]      bank_add_i,
        input  icache_xbar_pkg::master_id_t [icache_xbar_pkg::N_BANK-1:0] bank_id_i,

        // Current vector from the stimulus file
        input  int                                                        test_num_i,
        input  int                                                        vec_cyc_i,
        input  logic [2*icache_xbar_pkg::N_MASTER-1:0]                    exp_bank_i,
        input  logic [4*icache_xbar_pkg::N_MASTER-1:0]                    exp_cyc_i,
        input  logic                                                      run_done_i,

        output int                                                        err_cnt_o,
        output logic                                                      report_done_o
);

        int                                                      cur_test;
        int                                                      test_checks;
        int                                                      test_errs;
        int                                                      test_cnt;
        int                                                      check_cnt;
        logic [icache_xbar_pkg::N_MASTER-1:0]                    resp_exp;   // Grant seen last cycle
        icache_xbar_pkg::data_t [icache_xbar_pkg::N_MASTER-1:0]  resp_data;  // Inverted address

        initial
        begin
                cur_test      = 0;
                test_checks   = 0;
                test_errs     = 0;
                test_cnt      = 0;
                check_cnt     = 0;
                err_cnt_o     = 0;
                report_done_o = 1'b0;
                resp_exp      = '0;
                resp_data     = '0;
        end

        task automatic check_value(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        begin
                check_cnt++;
                test_checks++;
                if (act_val !== exp_val)
                begin
                        err_cnt_o++;
                        test_errs++;
                        $display("** Error at %0t: %s expected %h, got %h",
                                 $time, name, exp_val, act_val);
                end
        end
        endtask

        task automatic report_test();
        begin
                test_cnt++;
                if (test_errs == 0)
                        $display("Test %0d passed, %0d checks", cur_test, test_checks);
                else
                        $display("Test %0d failed, %0d of %0d checks wrong",
                                 cur_test, test_errs, test_checks);
        end
        endtask

        ///////////////////////////////////////////////////
        // Mid-cycle compare, inputs settled since +2 ns
        ///////////////////////////////////////////////////

        always @(negedge clk)
        begin
                int   win;
                int   best;
                logic exp_req;
                logic exp_gnt;

                if (arst_n_i && test_num_i != 0 && !report_done_o)
                begin
                        if (test_num_i != cur_test)
                        begin
                                if (cur_test != 0)
                                        report_test();     // Previous test is over
                                cur_test    = test_num_i;
                                test_checks = 0;
                                test_errs   = 0;
                        end

                        // Bank answers one cycle after the grant, on the owner only
                        for (int m = 0; m < icache_xbar_pkg::N_MASTER; m++)
                        begin
                                check_value($sformatf("data_r_valid_o[%0d]", m),
                                            resp_exp[m], r_valid_i[m]);
                                if (resp_exp[m])
                                        check_value($sformatf("data_r_rdata_o[%0d]", m),
                                                    resp_data[m], r_rdata_i[m]);
                        end

                        // Winner is the pending master with the earliest grant slot
                        for (int b = 0; b < icache_xbar_pkg::N_BANK; b++)
                        begin
                                exp_req = 1'b0;
                                win     = 0;
                                best    = 16;
                                for (int m = 0; m < icache_xbar_pkg::N_MASTER; m++)
                                begin
                                        if (req_i[m] && exp_bank_i[2*m +: 2] == b)
                                        begin
                                                exp_req = 1'b1;
                                                if (exp_cyc_i[4*m +: 4] < best)
                                                begin
                                                        best = exp_cyc_i[4*m +: 4];
                                                        win  = m;
                                                end
                                        end
                                end
                                check_value($sformatf("data_req_o[%0d]", b), exp_req, bank_req_i[b]);
                                if (exp_req)
                                begin
                                        check_value($sformatf("data_add_o[%0d]", b),
                                                    add_i[win], bank_add_i[b]);
                                        check_value($sformatf("data_id_o[%0d]", b),
                                                    32'd1 << win, bank_id_i[b]);  // One-hot tag
                                end
                        end

                        // Grant only in the slot the file names
                        for (int m = 0; m < icache_xbar_pkg::N_MASTER; m++)
                        begin
                                exp_gnt = req_i[m] && (exp_cyc_i[4*m +: 4] == vec_cyc_i);
                                check_value($sformatf("data_gnt_o[%0d]", m), exp_gnt, gnt_i[m]);
                                resp_exp[m]  = exp_gnt;
                                resp_data[m] = ~add_i[m];
                        end

                        if (run_done_i)
                        begin
                                report_test();
                                $display("Summary: %0d tests, %0d checks, %0d errors",
                                         test_cnt, check_cnt, err_cnt_o);
                                report_done_o = 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
        output logic clk_o,
        output logic arst_n_o
);

        // 20 ns period
        initial
        begin
                clk_o = 1'b0;
                forever #10 clk_o = ~clk_o;
        end

        // Reset held over the first two rising edges
        initial
        begin
                arst_n_o = 1'b0;
                repeat (2) @(posedge clk_o);
                #2 arst_n_o = 1'b1;     // Released with the other inputs
        end

endmodule

`default_nettype wire

// File: tests/tb_icache_xbar.sv
// Crossbar testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_icache_xbar;

        localparam int REC_WORDS  = 10;     // Words per vector in the data file
        localparam int MAX_REC    = 32;

        logic                                                        clk;
        logic                                                        arst_n_i;

        // DUT ports
        logic [icache_xbar_pkg::N_MASTER-1:0]                        data_req_i;
        icache_xbar_pkg::addr_t [icache_xbar_pkg::N_MASTER-1:0]      data_add_i;
        logic [icache_xbar_pkg::N_MASTER-1:0]                        data_gnt_o;
        logic [icache_xbar_pkg::N_MASTER-1:0]                        data_r_valid_o;
        icache_xbar_pkg::data_t [icache_xbar_pkg::N_MASTER-1:0]      data_r_rdata_o;
        logic [icache_xbar_pkg::N_BANK-1:0]                          data_req_o;
        icache_xbar_pkg::addr_t [icache_xbar_pkg::N_BANK-1:0]        data_add_o;
        icache_xbar_pkg::master_id_t [icache_xbar_pkg::N_BANK-1:0]   data_id_o;
        logic [icache_xbar_pkg::N_BANK-1:0]                          data_gnt_i;
        logic [icache_xbar_pkg::N_BANK-1:0]                          data_r_valid_i;
        icache_xbar_pkg::master_id_t [icache_xbar_pkg::N_BANK-1:0]   data_r_id_i;
        icache_xbar_pkg::data_t [icache_xbar_pkg::N_BANK-1:0]        data_r_rdata_i;

        // Vector state shared with the checker
        logic [31:0]                                 stim_mem [0:REC_WORDS*MAX_REC-1];
        int                                          test_num;
        int                                          vec_cyc;   // Cycles since vector start
        logic [2*icache_xbar_pkg::N_MASTER-1:0]      exp_bank;
        logic [4*icache_xbar_pkg::N_MASTER-1:0]      exp_cyc;
        logic                                        run_done;
        logic                                        stim_err;
        int                                          err_cnt;
        logic                                        report_done;
        int                                          cyc_cnt   = 0;
        int                                          cyc_limit = 0;

        // Bank model state latched mid-cycle
        logic [icache_xbar_pkg::N_BANK-1:0]                          bank_acc;
        icache_xbar_pkg::addr_t [icache_xbar_pkg::N_BANK-1:0]        bank_addr;
        icache_xbar_pkg::master_id_t [icache_xbar_pkg::N_BANK-1:0]   bank_id;

        tb_clock_gen i_tb_clock_gen (.clk_o(clk), .arst_n_o(arst_n_i));

        icache_xbar_top i_icache_xbar_top
        (
                .clk            ( clk            ),
                .arst_n_i       ( arst_n_i       ),
                .data_req_i     ( data_req_i     ),
                .data_add_i     ( data_add_i     ),
                .data_gnt_o     ( data_gnt_o     ),
                .data_r_valid_o ( data_r_valid_o ),
                .data_r_rdata_o ( data_r_rdata_o ),
                .data_req_o     ( data_req_o     ),
                .data_add_o     ( data_add_o     ),
                .data_id_o      ( data_id_o      ),
                .data_gnt_i     ( data_gnt_i     ),
                .data_r_valid_i ( data_r_valid_i ),
                .data_r_id_i    ( data_r_id_i    ),
                .data_r_rdata_i ( data_r_rdata_i )
        );

        tb_checker i_tb_checker
        (
                .clk (clk), .arst_n_i (arst_n_i),
                .req_i (data_req_i), .add_i (data_add_i), .gnt_i (data_gnt_o),
                .r_valid_i (data_r_valid_o), .r_rdata_i (data_r_rdata_o),
                .bank_req_i (data_req_o), .bank_add_i (data_add_o), .bank_id_i (data_id_o),
                .test_num_i (test_num), .vec_cyc_i (vec_cyc),
                .exp_bank_i (exp_bank), .exp_cyc_i (exp_cyc), .run_done_i (run_done),
                .err_cnt_o (err_cnt), .report_done_o (report_done)
        );

        ///////////////////////////////////////////////////
        // Bank models answer one cycle after acceptance
        ///////////////////////////////////////////////////

        always @(negedge clk)
        begin
                bank_acc  = data_req_o & data_gnt_i;
                bank_addr = data_add_o;
                bank_id   = data_id_o;
        end

        always @(posedge clk)
        begin
                #2;
                data_r_valid_i = bank_acc;
                data_r_id_i    = bank_id;                // Tag goes back unchanged
                for (int b = 0; b < icache_xbar_pkg::N_BANK; b++)
                        data_r_rdata_i[b] = ~bank_addr[b];
        end

        ///////////////////////////////////////////////////
        // Stimulus driver
        ///////////////////////////////////////////////////

        initial
        begin
                integer                               seed;
                int                                   n_rec;
                int                                   base;
                int                                   k;
                int                                   hold;
                logic [icache_xbar_pkg::N_BANK-1:0]   gnt_mask;
                logic [icache_xbar_pkg::N_MASTER-1:0] pending;   // Requests not yet granted

                seed           = 71313;
                data_req_i     = '0;
                data_add_i     = '0;
                data_gnt_i     = '0;
                data_r_valid_i = '0;
                data_r_id_i    = '0;
                data_r_rdata_i = '0;
                bank_acc       = '0;
                bank_addr      = '0;
                bank_id        = '0;
                test_num       = 0;
                vec_cyc        = 0;
                exp_bank       = '0;
                exp_cyc        = '0;
                run_done       = 1'b0;
                stim_err       = 1'b0;

                for (int i = 0; i < REC_WORDS*MAX_REC; i++)
                        stim_mem[i] = '0;               // Test number 0 ends the list
                $readmemh("tests/xbar_stimulus.mem", stim_mem);
                n_rec = 0;
                while (n_rec < MAX_REC && stim_mem[n_rec*REC_WORDS] != 0)
                        n_rec++;
                cyc_limit = n_rec * (icache_xbar_pkg::N_MASTER + 2) + 50;
                if (n_rec == 0)
                begin
                        $display("Stimulus file holds no vectors");
                        stim_err = 1'b1;
                end

                wait (arst_n_i === 1'b1);
                @(posedge clk);
                #2;
                for (int r = 0; r < n_rec; r++)
                begin
                        base     = r * REC_WORDS;
                        test_num = stim_mem[base];
                        pending  = stim_mem[base+1][icache_xbar_pkg::N_MASTER-1:0];
                        for (int m = 0; m < icache_xbar_pkg::N_MASTER; m++)
                        begin
                                if (stim_mem[base+2+m] == 32'hFFFF_FFFF)
                                        data_add_i[m] = $random(seed);  // Filler address
                                else
                                        data_add_i[m] = stim_mem[base+2+m];
                        end
                        gnt_mask = stim_mem[base+6][icache_xbar_pkg::N_BANK-1:0];
                        hold     = stim_mem[base+7];
                        exp_bank = stim_mem[base+8][2*icache_xbar_pkg::N_MASTER-1:0];
                        exp_cyc  = stim_mem[base+9][4*icache_xbar_pkg::N_MASTER-1:0];
                        k          = 0;
                        vec_cyc    = 0;
                        data_req_i = pending;
                        data_gnt_i = (hold > 0) ? gnt_mask : '1;

                        // Each master holds req and address until granted
                        while (pending != '0)
                        begin
                                @(negedge clk);
                                pending = pending & ~data_gnt_o;
                                @(posedge clk);
                                #2;
                                k++;
                                vec_cyc    = k;
                                data_req_i = pending;
                                data_gnt_i = (k < hold) ? gnt_mask : '1;  // Stall window
                        end
                        @(posedge clk);                 // Idle cycle lets the response land
                        #2;
                end
                run_done = 1'b1;
        end

        // Run guard sized from the vector count
        always @(posedge clk)
        begin
                cyc_cnt++;
                if (cyc_cnt > cyc_limit)
                begin
                        $display("Timeout: run did not finish within %0d cycles", cyc_limit);
                        $display("*** TEST FAILED ***");
                        $finish;
                end
        end

        initial
        begin
                wait (report_done === 1'b1 || stim_err === 1'b1);
                if (err_cnt == 0 && !stim_err)
                        $display("*** TEST PASSED ***");
                else
                        $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

`default_nettype wire

// File: tests/xbar_stimulus.mem
// test req addr_m0 addr_m1 addr_m2 addr_m3 gnt_mask hold exp_bank exp_cyc
// FFFFFFFF address is random filler, exp_bank 2 bits and exp_cyc 1 nibble per master, m0 lowest
// Single fetch
00000001 1 00001000 FFFFFFFF FFFFFFFF FFFFFFFF F 0 00 FFF0
00000001 4 FFFFFFFF FFFFFFFF 00002048 FFFFFFFF F 0 20 F0FF
// Bank routing
00000002 2 FFFFFFFF 000010A4 FFFFFFFF FFFFFFFF F 0 04 FF0F
00000002 8 FFFFFFFF FFFFFFFF FFFFFFFF 000020C8 F 0 80 0FFF
// Tagging
00000003 8 FFFFFFFF FFFFFFFF FFFFFFFF 00004000 F 0 00 0FFF
00000003 4 FFFFFFFF FFFFFFFF 000050A0 FFFFFFFF F 0 10 F0FF
// Round-robin, bank 3 from reset then bank 1 from pointer 3
00000004 F 00000060 00000160 00000260 00000360 F 0 FF 3210
00000004 E FFFFFFFF 00000420 00000520 00000620 F 0 54 021F
// Back-pressure, bank 2 stalls 3 cycles, then bank 0 stalls 2
00000005 1 00007040 FFFFFFFF FFFFFFFF FFFFFFFF B 3 02 FFF3
00000005 E FFFFFFFF 00008000 00008100 00008060 E 2 C0 032F
// Parallel banks
00000006 F 00009060 00009140 00009220 00009300 F 0 1B 0000
00000006 F 0000A000 0000A040 0000A100 0000A140 F 0 88 0110
